// ==== bench/aembTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aembTb;
   import aembPkg::*;

   localparam int MEM_WORDS = 256;
   localparam int MAX_FETCH = 64;

   logic              nclk;
   logic              nrst;
   logic              sysInt;
   logic              sysExc;
   logic              iwbStb;
   logic [31:0]       iwbAdr;
   logic [31:0]       iwbDat;
   logic              iwbAck;
   logic              dwbStb;
   logic              dwbWe;
   logic [31:0]       dwbAdr;
   logic [31:0]       dwbDatOut;
   logic [31:0]       dwbDatIn;
   logic              dwbAck;
   logic [31:0]       loadDat;
   logic [1:0]        trapState;

   // Program image and expected traffic
   instrWord_t        prog [0:MEM_WORDS-1];
   logic [ADDR_W-1:0] expFetch [0:MAX_FETCH-1];
   logic [ADDR_W-1:0] expDAdr [0:MAX_FETCH-1];
   logic              expDWe [0:MAX_FETCH-1];
   logic [31:0]       expDDat [0:MAX_FETCH-1];
   int                expDCount;

   // Monitor state
   logic              monOn;
   logic              seqOn;
   logic              loadDue;
   logic [31:0]       loadExp;
   logic              stbPrev;
   logic              vecArmed;
   logic              vecSeen;
   logic [ADDR_W-1:0] vecExp;
   int                fetchIdx;
   int                fetchWant;
   int                dataIdx;
   int                intCycles;
   int                excCycles;

   // Results
   string             testName;
   int                errCount;
   int                errAtStart;
   int                checkCount;
   int                testCount;
   int                failCount;

   tbClock clkGen_i (
      .nclk_o (nclk)
   );

   aembCore dut_i (
      .nclk        (nclk),
      .nrst        (nrst),
      .sysInt_i    (sysInt),
      .sysExc_i    (sysExc),
      .iwbStb_o    (iwbStb),
      .iwbAdr_o    (iwbAdr),
      .iwbDat_i    (iwbDat),
      .iwbAck_i    (iwbAck),
      .dwbStb_o    (dwbStb),
      .dwbWe_o     (dwbWe),
      .dwbAdr_o    (dwbAdr),
      .dwbDat_o    (dwbDatOut),
      .dwbDat_i    (dwbDatIn),
      .dwbAck_i    (dwbAck),
      .loadDat_o   (loadDat),
      .trapState_o (trapState)
   );

   busModel bus_i (
      .nclk     (nclk),
      .iwbStb_i (iwbStb),
      .iwbAdr_i (iwbAdr),
      .iwbDat_o (iwbDat),
      .iwbAck_o (iwbAck),
      .dwbStb_i (dwbStb),
      .dwbWe_i  (dwbWe),
      .dwbAdr_i (dwbAdr),
      .dwbDat_i (dwbDatOut),
      .dwbDat_o (dwbDatIn),
      .dwbAck_o (dwbAck)
   );

   // Data memory contents depend on every address bit
   function automatic logic [31:0] fillWord(input logic [ADDR_W-1:0] adr);
      return (adr * 32'h9e37_79b1) ^ {adr[15:0], adr[31:16]} ^ 32'h5a0f_c3a5;
   endfunction

   function automatic instrWord_t regForm(input logic [5:0] op, input logic [4:0] ra,
                                          input logic [4:0] rb);
      instrWord_t w;
      w = '0;
      w.typeA.opcode = op;
      w.typeA.ra = ra;
      w.typeA.rb = rb;
      return w;
   endfunction

   function automatic instrWord_t immForm(input logic [5:0] op, input logic [4:0] ra,
                                          input logic [15:0] imm);
      instrWord_t w;
      w = '0;
      w.typeB.opcode = op;
      w.typeB.ra = ra;
      w.typeB.imm = imm;
      return w;
   endfunction

   // Walks prog from reset and records fetch order and data accesses
   function automatic void refWalk(input int nFetch);
      logic [ADDR_W-1:0] seqAdr;
      logic [ADDR_W-1:0] tgt;
      logic [ADDR_W-1:0] adr;
      logic [31:0]       dVal;
      logic              tgtValid;
      logic              slotDue;
      logic [5:0]        op;
      instrWord_t        w;
      int                i;
      int                k;
      seqAdr = RESET_PC;
      tgt = '0;
      tgtValid = 1'b0;
      slotDue = 1'b0;
      expDCount = 0;
      for (i = 0; i < nFetch; i++) begin
         // Delay slot goes first, then the target
         if (tgtValid && !slotDue) begin
            adr = tgt;
            tgtValid = 1'b0;
         end else begin
            adr = seqAdr;
         end
         slotDue = 1'b0;
         expFetch[i] = adr;
         seqAdr = adr + 32'd4;
         w = prog[adr[9:2]];
         op = w.typeA.opcode;
         if (op == OP_BRA || op == OP_BRAI) begin
            if (op == OP_BRAI) begin
               tgt = adr + {{16{w.typeB.imm[15]}}, w.typeB.imm};
            end else begin
               tgt = {25'd0, w.typeA.rb, 2'b00};
            end
            tgtValid = 1'b1;
            slotDue = w.typeA.ra[4];
         end else if (op == OP_LW || op == OP_SW) begin
            expDAdr[expDCount] = {16'd0, w.typeB.imm};
            expDWe[expDCount] = (op == OP_SW);
            if (op == OP_SW) begin
               // Store carries its own pc
               dVal = adr;
            end else begin
               dVal = fillWord(expDAdr[expDCount]);
               for (k = 0; k < expDCount; k++) begin
                  if (expDWe[k] && expDAdr[k] == expDAdr[expDCount]) begin
                     dVal = expDDat[k];
                  end
               end
            end
            expDDat[expDCount] = dVal;
            expDCount++;
         end
      end
   endfunction

   task automatic checkAddr(input string name, input logic [ADDR_W-1:0] got,
                            input logic [ADDR_W-1:0] exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("FAILED %s: %s = %h, expected %h", testName, name, got, exp);
      end
   endtask

   task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("FAILED %s: %s = %h, expected %h", testName, name, got, exp);
      end
   endtask

   task automatic checkState(input string name, input logic [1:0] got, input logic [1:0] exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("FAILED %s: %s = %h, expected %h", testName, name, got, exp);
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("FAILED %s: %s = %h, expected %h", testName, name, got, exp);
      end
   endtask

   // Compare process runs mid-cycle where everything is settled
   always @(negedge nclk) begin
      if (monOn) begin
         // loadDat_o follows the ack edge
         if (loadDue) begin
            checkWord("loadDat_o", loadDat, loadExp);
            loadDue = 1'b0;
         end
         if (iwbStb && iwbAck) begin
            if (seqOn && fetchIdx < fetchWant) begin
               checkAddr("iwbAdr_o", iwbAdr, expFetch[fetchIdx]);
            end
            fetchIdx++;
         end
         // Fetch held off for the whole data access
         if (dwbStb) begin
            checkFlag("iwbStb_o", iwbStb, 1'b0);
         end
         if (dwbStb && dwbAck) begin
            if (seqOn && dataIdx < expDCount) begin
               checkAddr("dwbAdr_o", dwbAdr, expDAdr[dataIdx]);
               checkFlag("dwbWe_o", dwbWe, expDWe[dataIdx]);
               if (expDWe[dataIdx]) begin
                  checkWord("dwbDat_o", dwbDatOut, expDDat[dataIdx]);
               end else begin
                  loadDue = 1'b1;
                  loadExp = expDDat[dataIdx];
               end
            end
            dataIdx++;
         end
         // First fetch issued after a trap cycle
         if (iwbStb && !stbPrev && vecArmed) begin
            checkAddr("iwbAdr_o", iwbAdr, vecExp);
            vecArmed = 1'b0;
            vecSeen = 1'b1;
         end
         if (trapState == FSM_HWINT) begin
            intCycles++;
         end
         if (trapState == FSM_HWEXC) begin
            excCycles++;
         end
         if (trapState != FSM_RUN) begin
            vecArmed = 1'b1;
         end
         stbPrev = iwbStb;
      end
   end

   task automatic clearProgram;
      int k;
      for (k = 0; k < MEM_WORDS; k++) begin
         prog[k] = '0;
      end
   endtask

   // Reset for 10 cycles with the program loaded
   task automatic startTest(input string name);
      int k;
      @(posedge nclk);
      #1;
      testName = name;
      errAtStart = errCount;
      monOn = 1'b0;
      seqOn = 1'b0;
      nrst = 1'b0;
      sysInt = 1'b0;
      sysExc = 1'b0;
      repeat (10) begin
         @(posedge nclk);
      end
      #1;
      for (k = 0; k < MEM_WORDS; k++) begin
         bus_i.imem[k] = prog[k];
         bus_i.dmem[k] = fillWord(k * 4);
      end
      fetchIdx = 0;
      dataIdx = 0;
      loadDue = 1'b0;
      stbPrev = 1'b0;
      vecArmed = 1'b0;
      vecSeen = 1'b0;
      intCycles = 0;
      excCycles = 0;
      checkState("trapState_o", trapState, FSM_RUN);
      checkFlag("iwbStb_o", iwbStb, 1'b0);
      checkFlag("dwbStb_o", dwbStb, 1'b0);
      nrst = 1'b1;
      monOn = 1'b1;
   endtask

   task automatic endTest;
      // Room for the trailing load check
      repeat (2) begin
         @(posedge nclk);
      end
      #1;
      testCount++;
      if (errCount == errAtStart) begin
         $display("Test %0d %s: passed", testCount, testName);
      end else begin
         failCount++;
         $display("Test %0d %s: %0d failing checks", testCount, testName,
                  errCount - errAtStart);
      end
   endtask

   task automatic waitFetches(input int n, input int limit);
      int cyc;
      cyc = 0;
      while (fetchIdx < n && cyc < limit) begin
         @(posedge nclk);
         #1;
         cyc++;
      end
      if (fetchIdx < n) begin
         errCount++;
         $display("Timeout in %s: only %0d of %0d fetches completed", testName, fetchIdx, n);
      end
   endtask

   task automatic waitData(input int n, input int limit);
      int cyc;
      cyc = 0;
      while (dataIdx < n && cyc < limit) begin
         @(posedge nclk);
         #1;
         cyc++;
      end
      if (dataIdx < n) begin
         errCount++;
         $display("Timeout in %s: only %0d of %0d data accesses done", testName, dataIdx, n);
      end
   endtask

   // Trap lines drop after width cycles even while the trap is still awaited
   task automatic waitTrap(input int width, input int limit, output int held);
      int cyc;
      cyc = 0;
      while (trapState == FSM_RUN && cyc < limit) begin
         @(posedge nclk);
         #1;
         cyc++;
         if (cyc == width) begin
            sysInt = 1'b0;
            sysExc = 1'b0;
         end
      end
      held = cyc;
      if (trapState == FSM_RUN) begin
         errCount++;
         $display("Timeout in %s: trap state never left run", testName);
      end
   endtask

   // Counts come from the monitor over the whole test
   task automatic expectTraps(input int intExp, input int excExp);
      checkCount++;
      if (intCycles != intExp || excCycles != excExp) begin
         errCount++;
         $display("Trap count wrong in %s: %0d int and %0d exc cycles, wanted %0d and %0d",
                  testName, intCycles, excCycles, intExp, excExp);
      end
   endtask

   // Straight-line or branching program checked against refWalk
   task automatic runProgram(input string name, input int nFetch);
      refWalk(nFetch);
      fetchWant = nFetch;
      startTest(name);
      seqOn = 1'b1;
      waitFetches(nFetch, 40 * nFetch);
      waitData(expDCount, 100);
      endTest();
   endtask

   // Interrupt and exception lines raised together for some cycles
   task automatic runTrap(input string name, input logic useInt, input logic useExc,
                          input int width, input logic [ADDR_W-1:0] vec);
      int held;
      startTest(name);
      vecExp = vec;
      waitFetches(3, 100);
      sysInt = useInt;
      sysExc = useExc;
      if (width >= 2) begin
         // Trap cycle can come while the lines are still high
         waitTrap(width, 20, held);
         checkState("trapState_o", trapState, useExc ? FSM_HWEXC : FSM_HWINT);
         @(posedge nclk);
         #1;
         held++;
         checkState("trapState_o", trapState, FSM_RUN);
         // Rest of the pulse
         while (held < width) begin
            @(posedge nclk);
            #1;
            held++;
         end
         sysInt = 1'b0;
         sysExc = 1'b0;
         waitFetches(fetchIdx + 2, 100);
         if (!vecSeen) begin
            errCount++;
            $display("No fetch was issued after the trap in %s", testName);
         end
      end else begin
         repeat (width) begin
            @(posedge nclk);
         end
         #1;
         sysInt = 1'b0;
         sysExc = 1'b0;
         // Observation window for a trap that must not come
         repeat (12) begin
            @(posedge nclk);
         end
         #1;
      end
      expectTraps((width >= 2 && !useExc) ? 1 : 0, (width >= 2 && useExc) ? 1 : 0);
      endTest();
   endtask

   initial begin
      nrst = 1'b0;
      sysInt = 1'b0;
      sysExc = 1'b0;
      monOn = 1'b0;
      seqOn = 1'b0;
      loadDue = 1'b0;
      loadExp = '0;
      stbPrev = 1'b0;
      vecArmed = 1'b0;
      vecSeen = 1'b0;
      vecExp = '0;
      fetchIdx = 0;
      fetchWant = 0;
      dataIdx = 0;
      intCycles = 0;
      excCycles = 0;
      expDCount = 0;
      errCount = 0;
      errAtStart = 0;
      checkCount = 0;
      testCount = 0;
      failCount = 0;
      testName = "init";

      clearProgram();
      runProgram("straight line", 16);

      // 0x08 jumps to 0x28, 0x30 delayed to 0x50, 0x58 back to 0x38
      clearProgram();
      prog[2] = immForm(OP_BRAI, 5'h00, 16'h0020);
      prog[12] = immForm(OP_BRAI, 5'h10, 16'h0020);
      prog[22] = immForm(OP_BRAI, 5'h00, 16'hffe0);
      runProgram("relative branch", 16);

      // 0x04 to word 20, 0x58 delayed to word 3
      clearProgram();
      prog[1] = regForm(OP_BRA, 5'h00, 5'd20);
      prog[22] = regForm(OP_BRA, 5'h10, 5'd3);
      runProgram("absolute branch", 10);

      // Load, store, then a load of the stored word
      clearProgram();
      prog[1] = immForm(OP_LW, 5'h00, 16'h0100);
      prog[2] = immForm(OP_SW, 5'h00, 16'h0104);
      prog[3] = immForm(OP_LW, 5'h00, 16'h0104);
      runProgram("load and store", 8);

      clearProgram();
      runTrap("interrupt held", 1'b1, 1'b0, 4, VEC_HWINT);
      runTrap("interrupt glitch", 1'b1, 1'b0, 1, VEC_HWINT);
      runTrap("exception and interrupt", 1'b1, 1'b1, 3, VEC_HWEXC);

      $display("Tests %0d, failed tests %0d, checks %0d, failing checks %0d",
               testCount, failCount, checkCount, errCount);
      if (errCount == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/busModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module busModel (
   input  wire                        nclk,
   input  wire                        iwbStb_i,
   input  wire [aembPkg::ADDR_W-1:0]  iwbAdr_i,
   output logic [31:0]                iwbDat_o,
   output logic                       iwbAck_o,
   input  wire                        dwbStb_i,
   input  wire                        dwbWe_i,
   input  wire [aembPkg::ADDR_W-1:0]  dwbAdr_i,
   input  wire [31:0]                 dwbDat_i,
   output logic [31:0]                dwbDat_o,
   output logic                       dwbAck_o
);

   // Word arrays, filled by the testbench
   logic [31:0] imem [0:255];
   logic [31:0] dmem [0:255];

   logic [31:0] lfsr;
   logic        iBusy;
   logic        dBusy;
   int          iWait;
   int          dWait;

   // Galois form, one step per bit
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // Two bits, so 0 to 3 idle cycles
   task automatic pickDelay(output int d);
      logic [1:0] b;
      lfsr = lfsrStep(lfsr);
      b[0] = lfsr[0];
      lfsr = lfsrStep(lfsr);
      b[1] = lfsr[0];
      d = b;
   endtask

   initial begin
      lfsr = 32'hec7d5282;
      iBusy = 1'b0;
      dBusy = 1'b0;
      iWait = 0;
      dWait = 0;
      iwbAck_o = 1'b0;
      dwbAck_o = 1'b0;
      iwbDat_o = '0;
      dwbDat_o = '0;
   end

   // Both responders in one block so the LFSR order is fixed
   always @(posedge nclk) begin
      #1;
      // Instruction side
      if (iwbAck_o || !iwbStb_i) begin
         iwbAck_o = 1'b0;
         iBusy = 1'b0;
      end
      if (iwbStb_i) begin
         if (!iBusy) begin
            pickDelay(iWait);
            iBusy = 1'b1;
         end
         if (iWait == 0) begin
            iwbDat_o = imem[iwbAdr_i[9:2]];
            iwbAck_o = 1'b1;
         end else begin
            iWait = iWait - 1;
         end
      end
      // Data side, writes land in the ack cycle
      if (dwbAck_o || !dwbStb_i) begin
         dwbAck_o = 1'b0;
         dBusy = 1'b0;
      end
      if (dwbStb_i) begin
         if (!dBusy) begin
            pickDelay(dWait);
            dBusy = 1'b1;
         end
         if (dWait == 0) begin
            if (dwbWe_i) begin
               dmem[dwbAdr_i[9:2]] = dwbDat_i;
            end else begin
               dwbDat_o = dmem[dwbAdr_i[9:2]];
            end
            dwbAck_o = 1'b1;
         end else begin
            dWait = dWait - 1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== bench/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock (
   output logic nclk_o
);

   // 10 ns period, low at time zero
   initial begin
      nclk_o = 1'b0;
      forever begin
         #5;
         nclk_o = ~nclk_o;
      end
   end

endmodule

`default_nettype wire

// ==== common/aembPkg.sv ====
`default_nettype none

package aembPkg;

   // Bus address width for both buses
   localparam int ADDR_W = 32;

   // Fetch address out of reset
   localparam logic [ADDR_W-1:0] RESET_PC = 32'h0;

   // Trap vectors
   localparam logic [ADDR_W-1:0] VEC_HWINT = 32'h10;
   localparam logic [ADDR_W-1:0] VEC_HWEXC = 32'h20;

   // Trap state encoding
   localparam logic [1:0] FSM_RUN   = 2'd0;
   localparam logic [1:0] FSM_HWINT = 2'd1;
   localparam logic [1:0] FSM_HWEXC = 2'd2;

   // Branches, ra[4] carries the delay-slot flag
   localparam logic [5:0] OP_BRA  = 6'h26;
   localparam logic [5:0] OP_BRAI = 6'h2e;

   // Word load and store, both type B
   localparam logic [5:0] OP_LW = 6'h3a;
   localparam logic [5:0] OP_SW = 6'h3e;

   // Register form
   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [10:0] func;
   } typeA_t;

   // Immediate form
   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [15:0] imm;
   } typeB_t;

   // One fetched word, opcode[3] set means type B
   typedef union packed {
      typeA_t typeA;
      typeB_t typeB;
   } instrWord_t;

endpackage

`default_nettype wire

// ==== control/pipeCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeCtrl (
   input  wire                         nclk,
   input  wire                         nrst,
   input  wire                         sysInt_i,
   input  wire                         sysExc_i,
   input  wire                         iwbStb_i,
   input  wire                         iwbAck_i,
   input  wire                         dwbStb_i,
   input  wire                         dwbAck_i,
   input  wire                         braTaken_i,
   input  wire                         braDly_i,
   output logic                        runRst_o,
   output logic                        fRun_o,
   output logic                        dRun_o,
   output logic                        qRun_o,
   output logic                        trapGo_o,
   output logic [aembPkg::ADDR_W-1:0]  trapVec_o,
   output logic [1:0]                  trapState_o
);
   import aembPkg::*;

   logic [1:0] rstSync;
   logic [2:0] excHist;
   logic [2:0] intHist;
   logic [1:0] fsmState;
   logic [1:0] fsmNext;
   logic       excFire;
   logic       intFire;

   // Two-flop reset release, assert is immediate
   always_ff @(posedge nclk or negedge nrst) begin
      if (!nrst) begin
         rstSync <= 2'b00;
      end else begin
         rstSync <= {rstSync[0], 1'b1};
      end
   end
   assign runRst_o = rstSync[1];

   // Bubble while either bus waits on its ack
   assign qRun_o = ~((iwbStb_i & ~iwbAck_i) | (dwbStb_i & ~dwbAck_i));

   // Run bits drop for one cycle after a taken branch
   always_ff @(posedge nclk or negedge runRst_o) begin
      if (!runRst_o) begin
         fRun_o <= 1'b1;
         dRun_o <= 1'b1;
      end else begin
         // Plain branch stalls fetch
         fRun_o <= ~(braTaken_i & ~braDly_i);
         // Delayed branch
         dRun_o <= ~(braTaken_i & braDly_i);
      end
   end

   // Sample history, newest in bit 0
   always_ff @(posedge nclk or negedge runRst_o) begin
      if (!runRst_o) begin
         excHist <= 3'b000;
         intHist <= 3'b000;
      end else begin
         excHist <= {excHist[1:0], sysExc_i};
         intHist <= {intHist[1:0], sysInt_i};
      end
   end

   // One low then two high, so a held level fires once
   assign excFire = (excHist == 3'b011);
   assign intFire = (intHist == 3'b011);

   always_ff @(posedge nclk or negedge runRst_o) begin
      if (!runRst_o) begin
         fsmState <= FSM_RUN;
      end else begin
         fsmState <= fsmNext;
      end
   end

   // Trap states last one cycle
   always_comb begin
      case (fsmState)
         FSM_HWEXC: fsmNext = FSM_RUN;
         FSM_HWINT: fsmNext = FSM_RUN;
         default: begin
            // Exception has priority
            if (excFire) begin
               fsmNext = FSM_HWEXC;
            end else if (intFire) begin
               fsmNext = FSM_HWINT;
            end else begin
               fsmNext = FSM_RUN;
            end
         end
      endcase
   end

   assign trapState_o = fsmState;
   assign trapGo_o    = (fsmState != FSM_RUN);
   // Vector only matters while trapGo is high
   assign trapVec_o   = (fsmState == FSM_HWEXC) ? VEC_HWEXC : VEC_HWINT;

endmodule

`default_nettype wire

// ==== fetch/fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
   input  wire                         nclk,
   input  wire                         runRst_i,
   input  wire                         fRun_i,
   input  wire                         dRun_i,
   input  wire                         qRun_i,
   input  wire                         braTaken_i,
   input  wire                         braDly_i,
   input  wire [aembPkg::ADDR_W-1:0]   braTarget_i,
   input  wire                         trapGo_i,
   input  wire [aembPkg::ADDR_W-1:0]   trapVec_i,
   output logic                        iwbStb_o,
   output logic [aembPkg::ADDR_W-1:0]  iwbAdr_o,
   input  wire [31:0]                  iwbDat_i,
   input  wire                         iwbAck_i,
   output aembPkg::instrWord_t         instrWord_o,
   output logic                        wordValid_o,
   output logic [aembPkg::ADDR_W-1:0]  pcNow_o
);
   import aembPkg::*;

   logic [ADDR_W-1:0] nextSeq;
   logic [ADDR_W-1:0] pendTgt;
   logic              pendValid;
   logic              slotFirst;
   logic [ADDR_W-1:0] trapAdr;
   logic              trapPend;
   logic              startFetch;
   logic              useTarget;
   logic              wordDone;
   logic [ADDR_W-1:0] fetchAdr;

   assign wordDone = iwbStb_o & iwbAck_i;

   // Start only when idle with the last word decoded and no stall
   assign startFetch = ~iwbStb_o & ~wordValid_o & fRun_i & dRun_i & qRun_i;

   // Delay slot goes out before the pending target
   assign useTarget = pendValid & ~slotFirst;

   // Trap, then branch target, then next word
   always_comb begin
      if (trapGo_i) begin
         fetchAdr = trapVec_i;
      end else if (trapPend) begin
         fetchAdr = trapAdr;
      end else if (useTarget) begin
         fetchAdr = pendTgt;
      end else begin
         fetchAdr = nextSeq;
      end
   end

   always_ff @(posedge nclk or negedge runRst_i) begin
      if (!runRst_i) begin
         iwbStb_o    <= 1'b0;
         wordValid_o <= 1'b0;
         nextSeq     <= RESET_PC;
         pendValid   <= 1'b0;
         slotFirst   <= 1'b0;
         trapPend    <= 1'b0;
      end else begin
         wordValid_o <= wordDone;
         if (wordDone) begin
            iwbStb_o <= 1'b0;
         end
         if (startFetch) begin
            iwbStb_o  <= 1'b1;
            nextSeq   <= fetchAdr + ADDR_W'(4);
            trapPend  <= 1'b0;
            slotFirst <= 1'b0;
            // Vector fetch also discards a target still waiting
            if (useTarget || trapPend) begin
               pendValid <= 1'b0;
            end
         end
         // Branch seen in decode
         if (wordValid_o && braTaken_i) begin
            pendValid <= 1'b1;
            slotFirst <= braDly_i;
         end
         // Trap drops any branch still waiting
         if (trapGo_i) begin
            trapPend  <= ~startFetch;
            pendValid <= 1'b0;
            slotFirst <= 1'b0;
         end
      end
   end

   // Addresses and fetched word
   always_ff @(posedge nclk) begin
      if (startFetch) begin
         iwbAdr_o <= fetchAdr;
      end
      if (wordDone) begin
         instrWord_o <= iwbDat_i;
         pcNow_o     <= iwbAdr_o;
      end
      if (wordValid_o && braTaken_i) begin
         pendTgt <= braTarget_i;
      end
      if (trapGo_i) begin
         trapAdr <= trapVec_i;
      end
   end

endmodule

`default_nettype wire

// ==== flist.f ====
common/aembPkg.sv
control/pipeCtrl.sv
fetch/fetchUnit.sv
src/branchDecode.sv
src/dataPort.sv
src/aembCore.sv
bench/tbClock.sv
bench/busModel.sv
bench/aembTb.sv

// ==== src/aembCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module aembCore (
   input  wire         nclk,
   input  wire         nrst,
   input  wire         sysInt_i,
   input  wire         sysExc_i,
   output logic        iwbStb_o,
   output logic [31:0] iwbAdr_o,
   input  wire  [31:0] iwbDat_i,
   input  wire         iwbAck_i,
   output logic        dwbStb_o,
   output logic        dwbWe_o,
   output logic [31:0] dwbAdr_o,
   output logic [31:0] dwbDat_o,
   input  wire  [31:0] dwbDat_i,
   input  wire         dwbAck_i,
   output logic [31:0] loadDat_o,
   output logic [1:0]  trapState_o
);
   import aembPkg::*;

   // Control
   logic              runRst;
   logic              fRun;
   logic              dRun;
   logic              qRun;
   logic              trapGo;
   logic [ADDR_W-1:0] trapVec;

   // Fetch
   instrWord_t        instrWord;
   logic              wordValid;
   logic [ADDR_W-1:0] pcNow;

   // Decode
   logic              braTaken;
   logic              braDly;
   logic [ADDR_W-1:0] braTarget;
   logic              memReq;
   logic              memWe;
   logic [ADDR_W-1:0] memAdr;

   pipeCtrl ctrl_i (
      .nclk        (nclk),
      .nrst        (nrst),
      .sysInt_i    (sysInt_i),
      .sysExc_i    (sysExc_i),
      .iwbStb_i    (iwbStb_o),
      .iwbAck_i    (iwbAck_i),
      .dwbStb_i    (dwbStb_o),
      .dwbAck_i    (dwbAck_i),
      .braTaken_i  (braTaken),
      .braDly_i    (braDly),
      .runRst_o    (runRst),
      .fRun_o      (fRun),
      .dRun_o      (dRun),
      .qRun_o      (qRun),
      .trapGo_o    (trapGo),
      .trapVec_o   (trapVec),
      .trapState_o (trapState_o)
   );

   fetchUnit fetch_i (
      .nclk        (nclk),
      .runRst_i    (runRst),
      .fRun_i      (fRun),
      .dRun_i      (dRun),
      .qRun_i      (qRun),
      .braTaken_i  (braTaken),
      .braDly_i    (braDly),
      .braTarget_i (braTarget),
      .trapGo_i    (trapGo),
      .trapVec_i   (trapVec),
      .iwbStb_o    (iwbStb_o),
      .iwbAdr_o    (iwbAdr_o),
      .iwbDat_i    (iwbDat_i),
      .iwbAck_i    (iwbAck_i),
      .instrWord_o (instrWord),
      .wordValid_o (wordValid),
      .pcNow_o     (pcNow)
   );

   branchDecode decode_i (
      .instrWord_i (instrWord),
      .wordValid_i (wordValid),
      .pcNow_i     (pcNow),
      .braTaken_o  (braTaken),
      .braDly_o    (braDly),
      .braTarget_o (braTarget),
      .memReq_o    (memReq),
      .memWe_o     (memWe),
      .memAdr_o    (memAdr)
   );

   // Store data is the pc of the store, for tracing
   dataPort data_i (
      .nclk        (nclk),
      .runRst_i    (runRst),
      .memReq_i    (memReq),
      .memWe_i     (memWe),
      .memAdr_i    (memAdr),
      .storeDat_i  (pcNow),
      .dwbStb_o    (dwbStb_o),
      .dwbWe_o     (dwbWe_o),
      .dwbAdr_o    (dwbAdr_o),
      .dwbDat_o    (dwbDat_o),
      .dwbDat_i    (dwbDat_i),
      .dwbAck_i    (dwbAck_i),
      .loadDat_o   (loadDat_o)
   );

endmodule

`default_nettype wire

// ==== src/branchDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchDecode (
   input  wire aembPkg::instrWord_t    instrWord_i,
   input  wire                         wordValid_i,
   input  wire [aembPkg::ADDR_W-1:0]   pcNow_i,
   output logic                        braTaken_o,
   output logic                        braDly_o,
   output logic [aembPkg::ADDR_W-1:0]  braTarget_o,
   output logic                        memReq_o,
   output logic                        memWe_o,
   output logic [aembPkg::ADDR_W-1:0]  memAdr_o
);
   import aembPkg::*;

   logic [5:0]        opcode;
   logic              isTypeB;
   logic              isBranch;
   logic              isLoad;
   logic              isStore;
   logic [ADDR_W-1:0] relTarget;
   logic [ADDR_W-1:0] absTarget;

   // Opcode sits in the same place in both forms
   assign opcode  = instrWord_i.typeA.opcode;
   assign isTypeB = opcode[3];

   assign isBranch = (opcode == OP_BRA) || (opcode == OP_BRAI);
   assign isLoad   = (opcode == OP_LW);
   assign isStore  = (opcode == OP_SW);

   // pc plus sign-extended imm
   assign relTarget = pcNow_i + {{(ADDR_W-16){instrWord_i.typeB.imm[15]}},
                                 instrWord_i.typeB.imm};

   // rb names a word, so scale by four
   assign absTarget = {{(ADDR_W-7){1'b0}}, instrWord_i.typeA.rb, 2'b00};

   assign braTaken_o  = wordValid_i & isBranch;
   assign braDly_o    = wordValid_i & isBranch & instrWord_i.typeA.ra[4];
   assign braTarget_o = isTypeB ? relTarget : absTarget;

   // Data address straight from the zero-extended imm
   assign memReq_o = wordValid_i & (isLoad | isStore);
   assign memWe_o  = isStore;
   assign memAdr_o = {{(ADDR_W-16){1'b0}}, instrWord_i.typeB.imm};

endmodule

`default_nettype wire

// ==== src/dataPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataPort (
   input  wire                         nclk,
   input  wire                         runRst_i,
   input  wire                         memReq_i,
   input  wire                         memWe_i,
   input  wire [aembPkg::ADDR_W-1:0]   memAdr_i,
   input  wire [31:0]                  storeDat_i,
   output logic                        dwbStb_o,
   output logic                        dwbWe_o,
   output logic [aembPkg::ADDR_W-1:0]  dwbAdr_o,
   output logic [31:0]                 dwbDat_o,
   input  wire [31:0]                  dwbDat_i,
   input  wire                         dwbAck_i,
   output logic [31:0]                 loadDat_o
);

   logic reqStart;
   logic accDone;

   // New request only from an idle port
   assign reqStart = memReq_i & ~dwbStb_o;
   assign accDone  = dwbStb_o & dwbAck_i;

   always_ff @(posedge nclk or negedge runRst_i) begin
      if (!runRst_i) begin
         dwbStb_o <= 1'b0;
         dwbWe_o  <= 1'b0;
      end else begin
         if (reqStart) begin
            dwbStb_o <= 1'b1;
            dwbWe_o  <= memWe_i;
         end else if (accDone) begin
            dwbStb_o <= 1'b0;
         end
      end
   end

   // Address and data stay put until ack
   always_ff @(posedge nclk) begin
      if (reqStart) begin
         dwbAdr_o <= memAdr_i;
         dwbDat_o <= storeDat_i;
      end
      // Load result
      if (accDone && !dwbWe_o) begin
         loadDat_o <= dwbDat_i;
      end
   end

endmodule

`default_nettype wire
